/* all.f */
+incdir+src
src/ahbl_pkg.sv
src/aout_sample_pkg.sv
src/aout_sample_fifo.sv
src/aout_pwm.sv
src/aout_regs.sv
src/audio_out_top.sv
dv/audio_out_asserts.sv
dv/tb_audio_out.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_audio_out
FILELIST  = all.f
SIM_ARGS  = +verilator+error+limit+100
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTBENCH FAILED
PASS_MSG  = TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_audio_out.sv */
/*
 Testbench for the audio output block. One AHB-Lite transfer at a time,
 HREADY looped back from the subordinate so stalls hold the bus.
 Duty is measured over one PWM period inside each hold, so the hold
 interval must stay at 2 or more during the PWM tests.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module tb_audio_out
    import ahbl_pkg::*;
();

    localparam logic [31:0] SEED          = 32'ha52d_7d40;
    localparam int          PERIOD_CYCLES = 256;
    localparam logic [7:0]  HOLD_INTERVAL = 8'd3;
    localparam int          PWM_CYCLES    = 20000;
    localparam int          BUS_CYCLES    = 2000;
    localparam int          WATCHDOG      = 2 * (PWM_CYCLES + BUS_CYCLES);

    logic        clk_sys;
    logic        rst_n_sys;
    logic [3:0]  haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic        hready;
    logic [31:0] hwdata;
    logic        hready_resp;
    logic        hresp;
    logic [31:0] hrdata;
    logic        irq;
    logic        audio_l;
    logic        audio_r;
    logic        signed_mode;
    int          checks_passed;
    int          checks_failed;
    int          test_start_fails;
    int          assert_fails;

    audio_out_top u_dut (
        .clk_sys(clk_sys), .rst_n_sys(rst_n_sys), .haddr_i(haddr), .htrans_i(htrans),
        .hwrite_i(hwrite), .hsize_i(hsize), .hready_i(hready), .hwdata_i(hwdata),
        .hready_resp_o(hready_resp), .hresp_o(hresp), .hrdata_o(hrdata),
        .irq_o(irq), .audio_l_o(audio_l), .audio_r_o(audio_r)
    );

    bind audio_out_top audio_out_asserts u_asserts (
        .clk_sys(clk_sys), .rst_n_sys(rst_n_sys), .hready_resp_o(hready_resp_o),
        .hresp_o(hresp_o), .irq_o(irq_o), .audio_l_o(audio_l_o), .audio_r_o(audio_r_o),
        .fifo_full(fifo_full), .fifo_push(fifo_push), .fifo_level(fifo_level),
        .pwm_running(pwm_running), .thresh(u_regs.thresh_q)
    );

    // Single subordinate on the bus
    assign hready = hready_resp;

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_sys);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------
    // Checks and bookkeeping

    function automatic void check_value(input string what, input logic [31:0] got,
                                        input logic [31:0] expected);
        if (got === expected) begin
            checks_passed++;
        end else begin
            checks_failed++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endfunction

    function automatic void report_failure(input string msg);
        checks_failed++;
        $display("error at %0d ns: %s", $time, msg);
    endfunction

    function automatic void end_test(input string name);
        $display("test %s done, %0d failed checks", name, checks_failed - test_start_fails);
        test_start_fails = checks_failed;
    endfunction

    function automatic logic [31:0] csr_word(input logic en, input logic sgn,
                                             input logic [7:0] ivl, input logic [2:0] thr);
        csr_word = {13'd0, thr, ivl, 5'd0, sgn, 1'b0, en};
    endfunction

    // ----------------------------------------
    // Bus tasks

    task automatic bus_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int stalls);
        stalls = 0;
        err    = 1'b0;
        @(negedge clk_sys);
        haddr  = addr;
        htrans = NONSEQ;
        hwrite = write;
        hsize  = 3'd2;
        @(negedge clk_sys);
        htrans = IDLE;
        hwdata = write ? wdata : 32'h0;
        while (!hready_resp) begin
            err = err | hresp;
            stalls++;
            @(negedge clk_sys);
        end
        err   = err | hresp;
        rdata = hrdata;
        @(posedge clk_sys);
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        int          stalls;
        bus_transfer(1'b1, addr, data, rdata, err, stalls);
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        int   stalls;
        bus_transfer(1'b0, addr, 32'h0, data, err, stalls);
    endtask

    task automatic wait_fifo_empty();
        logic [31:0] csr;
        bus_read(`AOUT_OFS_CSR, csr);
        while (csr[26:24] != 3'd0) begin
            bus_read(`AOUT_OFS_CSR, csr);
        end
    endtask

    task automatic wait_stopped();
        logic [31:0] csr;
        bus_read(`AOUT_OFS_CSR, csr);
        while (csr[1]) begin
            bus_read(`AOUT_OFS_CSR, csr);
        end
    endtask

    // Push one sample, find its hold, skip a period, then count high cycles
    task automatic play_sample(input string what, input logic [3:0] addr,
                               input logic [31:0] data);
        logic [15:0] left;
        logic [15:0] right;
        int          high_l;
        int          high_r;
        left   = (addr == `AOUT_OFS_FIFO_MONO) ? data[15:0] : data[31:16];
        right  = data[15:0];
        high_l = 0;
        high_r = 0;
        bus_write(addr, data);
        wait_fifo_empty();
        repeat (PERIOD_CYCLES) @(negedge clk_sys);
        repeat (PERIOD_CYCLES) begin
            @(negedge clk_sys);
            if (audio_l) high_l++;
            if (audio_r) high_r++;
        end
        check_value({what, " left duty"}, high_l, {24'h0, left[15:8] ^ {signed_mode, 7'd0}});
        check_value({what, " right duty"}, high_r, {24'h0, right[15:8] ^ {signed_mode, 7'd0}});
    endtask

    // ----------------------------------------
    // Tests

    initial begin
        logic [31:0] tmp;
        logic [31:0] rd;
        logic [31:0] wr;
        logic [2:0]  thr;
        logic        err;
        int          stalls;
        int          high;
        void'($urandom(SEED));
        rst_n_sys = 1'b0;
        haddr = 4'h0;
        htrans = IDLE;
        hwrite = 1'b0;
        hsize = 3'd2;
        hwdata = 32'h0;
        signed_mode = 1'b0;
        checks_passed = 0;
        checks_failed = 0;
        test_start_fails = 0;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_n_sys = 1'b1;

        // Running may follow a random enable, so bit 1 is left out here
        for (int i = 0; i < 8; i++) begin
            tmp = $urandom();
            wr  = csr_word(tmp[0], tmp[2], tmp[15:8], tmp[18:16]);
            bus_write(`AOUT_OFS_CSR, wr);
            bus_read(`AOUT_OFS_CSR, rd);
            check_value("csr readback", rd & ~32'h2, wr | 32'h8);
        end
        bus_write(`AOUT_OFS_CSR, 32'h0);
        wait_stopped();
        bus_read(`AOUT_OFS_CSR, rd);
        check_value("idle csr", rd, 32'h8);
        end_test("register readback");

        for (int n = 1; n <= 4; n++) begin
            tmp = $urandom();
            thr = tmp[2:0];
            bus_write(`AOUT_OFS_CSR, csr_word(1'b0, 1'b0, 8'd0, thr));
            bus_write(`AOUT_OFS_FIFO, $urandom());
            bus_read(`AOUT_OFS_CSR, rd);
            @(negedge clk_sys);
            check_value("fifo level", {29'd0, rd[26:24]}, n);
            check_value("irq", {31'd0, irq}, (n <= int'(thr)) ? 32'd1 : 32'd0);
        end
        // Start the engine, refill, and push once more into a full FIFO
        bus_write(`AOUT_OFS_CSR, csr_word(1'b1, 1'b0, 8'd0, 3'd0));
        bus_write(`AOUT_OFS_FIFO, $urandom());
        bus_transfer(1'b1, `AOUT_OFS_FIFO, $urandom(), rd, err, stalls);
        if (stalls == 0) begin
            report_failure("push into a full FIFO completed without a wait state");
        end
        wait_fifo_empty();
        bus_write(`AOUT_OFS_CSR, 32'h0);
        wait_stopped();
        end_test("fifo level, irq and back-pressure");

        bus_transfer(1'b1, 4'hC, $urandom(), rd, err, stalls);
        if (!err) report_failure("write to an unmapped offset got no ERROR response");
        check_value("error wait cycles", stalls, 32'd1);
        bus_transfer(1'b0, 4'hC, 32'h0, rd, err, stalls);
        if (!err) report_failure("read from an unmapped offset got no ERROR response");
        end_test("error response");

        bus_write(`AOUT_OFS_CSR, csr_word(1'b1, 1'b0, HOLD_INTERVAL, 3'd0));
        for (int i = 0; i < 3; i++) begin
            play_sample("unsigned", `AOUT_OFS_FIFO, $urandom());
        end
        signed_mode = 1'b1;
        bus_write(`AOUT_OFS_CSR, csr_word(1'b1, 1'b1, HOLD_INTERVAL, 3'd0));
        for (int i = 0; i < 3; i++) begin
            play_sample("signed", `AOUT_OFS_FIFO, $urandom());
        end
        end_test("pwm duty");

        play_sample("mono signed", `AOUT_OFS_FIFO_MONO, $urandom());
        signed_mode = 1'b0;
        bus_write(`AOUT_OFS_CSR, csr_word(1'b1, 1'b0, HOLD_INTERVAL, 3'd0));
        play_sample("mono", `AOUT_OFS_FIFO_MONO, $urandom());
        bus_write(`AOUT_OFS_CSR, csr_word(1'b0, 1'b0, HOLD_INTERVAL, 3'd0));
        wait_stopped();
        high = 0;
        repeat (2 * PERIOD_CYCLES) begin
            @(negedge clk_sys);
            if (audio_l || audio_r) high++;
        end
        check_value("high cycles after stop", high, 32'd0);
        end_test("mono and stop");

        assert_fails = u_dut.u_asserts.fail_count;
        $display("summary: %0d checks passed, %0d failed, %0d assertion failures",
                 checks_passed, checks_failed, assert_fails);
        if (checks_failed == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* dv/audio_out_asserts.sv */
/*
 Concurrent checks on the audio output block, bound into audio_out_top.
 fail_count holds the number of failed checks.
 The threshold is taken from inside the register block.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module audio_out_asserts (
    input logic                     clk_sys,
    input logic                     rst_n_sys,
    input logic                     hready_resp_o,
    input logic                     hresp_o,
    input logic                     irq_o,
    input logic                     audio_l_o,
    input logic                     audio_r_o,
    input logic                     fifo_full,
    input logic                     fifo_push,
    input logic [`AOUT_LEVEL_W-1:0] fifo_level,
    input logic                     pwm_running,
    input logic [`AOUT_LEVEL_W-1:0] thresh
);

    int fail_count = 0;

    // Level interrupt follows the FIFO level at all times
    a_irq_level: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        irq_o == (fifo_level <= thresh))
        else begin
            fail_count++;
            $error("irq_o differs from level <= threshold");
        end

    // Wait states outside an ERROR only come from a full FIFO
    a_stall_full: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        (!hready_resp_o && !hresp_o) |-> fifo_full)
        else begin
            fail_count++;
            $error("wait state while the FIFO is not full");
        end

    // A stalled sample write pushes in the cycle its wait state ends
    a_push_on_release: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        ($rose(hready_resp_o) && !hresp_o) |-> fifo_push)
        else begin
            fail_count++;
            $error("stalled sample write not pushed when the wait state ended");
        end

    // ----------------------------------------
    // Two-cycle ERROR response
    a_err_first: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        $rose(hresp_o) |-> !hready_resp_o)
        else begin
            fail_count++;
            $error("ERROR did not start with HREADYOUT low");
        end

    a_err_second: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        (hresp_o && !hready_resp_o) |=> (hresp_o && hready_resp_o))
        else begin
            fail_count++;
            $error("ERROR second cycle missing");
        end

    a_err_end: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        (hresp_o && hready_resp_o) |=> !hresp_o)
        else begin
            fail_count++;
            $error("ERROR lasted more than two cycles");
        end

    // Outputs stay quiet while the engine is stopped
    a_quiet_stopped: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        !pwm_running |-> (!audio_l_o && !audio_r_o))
        else begin
            fail_count++;
            $error("audio output high while not running");
        end

endmodule

/* src/audio_out_top.sv */
/*
 Audio output block: AHB-Lite register port, sample FIFO and PWM engine,
 all on clk_sys. hready_i must carry the bus HREADY so that wait states
 of this port hold the next address phase.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module audio_out_top
    import ahbl_pkg::*;
    import aout_sample_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    rst_n_sys,
    input  logic [`AOUT_ADDR_W-1:0] haddr_i,
    input  logic [1:0]              htrans_i,
    input  logic                    hwrite_i,
    input  logic [2:0]              hsize_i,
    input  logic                    hready_i,
    input  logic [31:0]             hwdata_i,
    output logic                    hready_resp_o,
    output logic                    hresp_o,
    output logic [31:0]             hrdata_o,
    output logic                    irq_o,
    output logic                    audio_l_o,
    output logic                    audio_r_o
);

    logic                        fifo_push;
    fifo_word_u                  fifo_push_data;
    logic                        fifo_pop;
    fifo_word_u                  fifo_head;
    logic                        fifo_full;
    logic                        fifo_empty;
    logic [`AOUT_LEVEL_W-1:0]    fifo_level;
    logic                        pwm_enable;
    logic [`AOUT_INTERVAL_W-1:0] pwm_interval;
    logic                        pwm_running;

    aout_regs u_regs (
        .clk_sys       (clk_sys),
        .rst_n_sys     (rst_n_sys),
        .haddr_i       (haddr_i),
        .htrans_i      (htrans_e'(htrans_i)),
        .hwrite_i      (hwrite_i),
        .hsize_i       (hsize_i),
        .hready_i      (hready_i),
        .hwdata_i      (hwdata_i),
        .hready_resp_o (hready_resp_o),
        .hresp_o       (hresp_o),
        .hrdata_o      (hrdata_o),
        .full_i        (fifo_full),
        .level_i       (fifo_level),
        .running_i     (pwm_running),
        .push_o        (fifo_push),
        .push_data_o   (fifo_push_data),
        .enable_o      (pwm_enable),
        .interval_o    (pwm_interval),
        .irq_o         (irq_o)
    );

    aout_sample_fifo u_fifo (
        .clk_sys     (clk_sys),
        .rst_n_sys   (rst_n_sys),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .level_o     (fifo_level)
    );

    aout_pwm u_pwm (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .enable_i   (pwm_enable),
        .interval_i (pwm_interval),
        .head_i     (fifo_head),
        .empty_i    (fifo_empty),
        .pop_o      (fifo_pop),
        .running_o  (pwm_running),
        .audio_l_o  (audio_l_o),
        .audio_r_o  (audio_r_o)
    );

endmodule

/* src/aout_regs.sv */
/*
 AHB-Lite subordinate and control registers of the audio output block.
 Zero wait states, except a sample write to a full FIFO, which holds
 hready_resp_o low until a slot frees. Writes are taken as full words and
 byte lanes are ignored. Transfers wider than 32 bits and unmapped word
 offsets get the two-cycle ERROR response. hready_i must be the bus HREADY.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module aout_regs
    import ahbl_pkg::*;
    import aout_sample_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        rst_n_sys,
    input  logic [`AOUT_ADDR_W-1:0]     haddr_i,
    input  htrans_e                     htrans_i,
    input  logic                        hwrite_i,
    input  logic [2:0]                  hsize_i,
    input  logic                        hready_i,
    input  logic [31:0]                 hwdata_i,
    output logic                        hready_resp_o,
    output logic                        hresp_o,
    output logic [31:0]                 hrdata_o,
    input  logic                        full_i,
    input  logic [`AOUT_LEVEL_W-1:0]    level_i,
    input  logic                        running_i,
    output logic                        push_o,
    output fifo_word_u                  push_data_o,
    output logic                        enable_o,
    output logic [`AOUT_INTERVAL_W-1:0] interval_o,
    output logic                        irq_o
);

    // CSR bit positions
    localparam int CSR_EN      = 0;
    localparam int CSR_RUN     = 1;
    localparam int CSR_SGN     = 2;
    localparam int CSR_RDY     = 3;
    localparam int CSR_IVL_LSB = 8;
    localparam int CSR_THR_LSB = 16;
    localparam int CSR_LVL_LSB = 24;

    logic                        dph_valid_q;
    logic                        dph_write_q;
    logic                        dph_wide_q;
    logic [`AOUT_ADDR_W-1:0]     dph_addr_q;
    logic                        err_second_q;

    logic                        enable_q;
    logic                        signed_q;
    logic [`AOUT_INTERVAL_W-1:0] interval_q;
    logic [`AOUT_LEVEL_W-1:0]    thresh_q;

    logic [`AOUT_ADDR_W-1:0]     word_ofs;
    logic                        sel_csr;
    logic                        sel_fifo;
    logic                        sel_mono;
    logic                        bad_xfer;
    logic                        sample_wr;
    logic                        csr_wr;
    logic [31:0]                 csr_rdata;
    fifo_word_u                  bus_word;
    fifo_word_u                  sample_word;

    // ----------------------------------------
    // Address phase capture

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            dph_valid_q <= 1'b0;
            dph_write_q <= 1'b0;
            dph_wide_q  <= 1'b0;
            dph_addr_q  <= '0;
        end else if (hready_i) begin
            dph_valid_q <= (htrans_i == NONSEQ) || (htrans_i == SEQ);
            dph_write_q <= hwrite_i;
            dph_wide_q  <= hsize_i > 3'd2;
            dph_addr_q  <= haddr_i;
        end
    end

    // Byte offset bits do not take part in the decode
    assign word_ofs = {dph_addr_q[`AOUT_ADDR_W-1:2], 2'b00};
    assign sel_csr  = word_ofs == `AOUT_OFS_CSR;
    assign sel_fifo = word_ofs == `AOUT_OFS_FIFO;
    assign sel_mono = word_ofs == `AOUT_OFS_FIFO_MONO;

    assign bad_xfer  = dph_valid_q && (dph_wide_q || !(sel_csr || sel_fifo || sel_mono));
    assign sample_wr = dph_valid_q && dph_write_q && !dph_wide_q && (sel_fifo || sel_mono);
    assign csr_wr    = dph_valid_q && dph_write_q && !dph_wide_q && sel_csr;

    // ----------------------------------------
    // Response

    // First ERROR cycle holds HREADYOUT low, second one releases it
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            err_second_q <= 1'b0;
        end else begin
            err_second_q <= bad_xfer && !err_second_q;
        end
    end

    assign hready_resp_o = !((sample_wr && full_i) || (bad_xfer && !err_second_q));
    assign hresp_o       = bad_xfer ? HRESP_ERROR : HRESP_OKAY;

    // ----------------------------------------
    // Control register

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            enable_q   <= 1'b0;
            signed_q   <= 1'b0;
            interval_q <= `AOUT_INTERVAL_RST;
            thresh_q   <= `AOUT_THRESH_RST;
        end else if (csr_wr) begin
            enable_q   <= hwdata_i[CSR_EN];
            signed_q   <= hwdata_i[CSR_SGN];
            interval_q <= hwdata_i[CSR_IVL_LSB +: `AOUT_INTERVAL_W];
            thresh_q   <= hwdata_i[CSR_THR_LSB +: `AOUT_LEVEL_W];
        end
    end

    always_comb begin
        csr_rdata                                    = '0;
        csr_rdata[CSR_EN]                            = enable_q;
        csr_rdata[CSR_RUN]                           = running_i;
        csr_rdata[CSR_SGN]                           = signed_q;
        csr_rdata[CSR_RDY]                           = !full_i;
        csr_rdata[CSR_IVL_LSB +: `AOUT_INTERVAL_W]   = interval_q;
        csr_rdata[CSR_THR_LSB +: `AOUT_LEVEL_W]      = thresh_q;
        csr_rdata[CSR_LVL_LSB +: `AOUT_LEVEL_W]      = level_i;
    end

    // FIFO offsets read as zero
    assign hrdata_o = (dph_valid_q && !dph_write_q && sel_csr) ? csr_rdata : '0;

    // ----------------------------------------
    // Sample word and push

    always_comb begin
        bus_word.raw = hwdata_i;
        sample_word  = bus_word;
        // Mono copies the low half into the left channel as well
        if (sel_mono) begin
            sample_word.lr.l = bus_word.lr.r;
        end
        // Two's complement to offset binary
        sample_word.lr.l[`AOUT_SAMPLE_W-1] = sample_word.lr.l[`AOUT_SAMPLE_W-1] ^ signed_q;
        sample_word.lr.r[`AOUT_SAMPLE_W-1] = sample_word.lr.r[`AOUT_SAMPLE_W-1] ^ signed_q;
    end

    assign push_o      = sample_wr && !full_i;
    assign push_data_o = sample_word;

    assign enable_o   = enable_q;
    assign interval_o = interval_q;
    assign irq_o      = level_i <= thresh_q;

endmodule

/* src/aout_pwm.sv */
/*
 Two-channel PWM engine. One period is 256 clk_sys cycles and each output
 is high for as many cycles as its 8-bit duty. A sample is held for
 interval+1 periods; on underrun the last sample repeats. The interval is
 sampled at each sample boundary, so change it only while stopped.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module aout_pwm
    import aout_sample_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        rst_n_sys,
    input  logic                        enable_i,
    input  logic [`AOUT_INTERVAL_W-1:0] interval_i,
    input  fifo_word_u                  head_i,
    input  logic                        empty_i,
    output logic                        pop_o,
    output logic                        running_o,
    output logic                        audio_l_o,
    output logic                        audio_r_o
);

    logic                        running_q;
    logic [`AOUT_PWM_W-1:0]      ramp_q;
    logic [`AOUT_INTERVAL_W-1:0] rep_q;
    logic [`AOUT_PWM_W-1:0]      duty_l_q;
    logic [`AOUT_PWM_W-1:0]      duty_r_q;
    logic [`AOUT_PWM_W-1:0]      duty_l_next;
    logic [`AOUT_PWM_W-1:0]      duty_r_next;
    logic                        audio_l_q;
    logic                        audio_r_q;
    logic                        period_start;
    logic                        period_end;

    assign period_start = running_q && (ramp_q == '0);
    assign period_end   = ramp_q == '1;

    // Sample boundary once the repeat count has run out
    assign pop_o = period_start && (rep_q == '0) && !empty_i;

    // ----------------------------------------
    // Run control and counters

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            running_q <= 1'b0;
            ramp_q    <= '0;
            rep_q     <= '0;
        end else begin
            if (!running_q) begin
                running_q <= enable_i;
            end else if (!enable_i && period_end) begin
                running_q <= 1'b0;
            end
            // Counters park at zero so the first period start is a boundary
            if (!running_q) begin
                ramp_q <= '0;
                rep_q  <= '0;
            end else begin
                ramp_q <= ramp_q + 1'b1;
                if (period_start) begin
                    rep_q <= (rep_q == '0) ? interval_i : rep_q - 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Duty and outputs

    assign duty_l_next = pop_o ? head_i.lr.l[`AOUT_SAMPLE_W-1 -: `AOUT_PWM_W] : duty_l_q;
    assign duty_r_next = pop_o ? head_i.lr.r[`AOUT_SAMPLE_W-1 -: `AOUT_PWM_W] : duty_r_q;

    // Outputs lag the ramp by one cycle and see the new duty at once
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            duty_l_q  <= '0;
            duty_r_q  <= '0;
            audio_l_q <= 1'b0;
            audio_r_q <= 1'b0;
        end else if (!running_q) begin
            duty_l_q  <= '0;
            duty_r_q  <= '0;
            audio_l_q <= 1'b0;
            audio_r_q <= 1'b0;
        end else begin
            duty_l_q  <= duty_l_next;
            duty_r_q  <= duty_r_next;
            audio_l_q <= ramp_q < duty_l_next;
            audio_r_q <= ramp_q < duty_r_next;
        end
    end

    assign running_o = running_q;
    assign audio_l_o = audio_l_q;
    assign audio_r_o = audio_r_q;

endmodule

/* src/aout_sample_fifo.sv */
/*
 Synchronous sample FIFO, four entries of one stereo word each.
 Pushing while full or popping while empty is not guarded here; the
 register block and the PWM engine never do either.
*/
`timescale 1ns/1ps
`include "aout_defines.svh"

module aout_sample_fifo
    import aout_sample_pkg::*;
(
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    input  logic                     push_i,
    input  fifo_word_u               push_data_i,
    input  logic                     pop_i,
    output fifo_word_u               head_o,
    output logic                     full_o,
    output logic                     empty_o,
    output logic [`AOUT_LEVEL_W-1:0] level_o
);

    localparam int AW = `AOUT_FIFO_ADDR_W;

    fifo_word_u               mem_q [`AOUT_FIFO_DEPTH];
    logic [AW:0]              wptr_q;
    logic [AW:0]              rptr_q;
    logic [`AOUT_LEVEL_W-1:0] level_q;

    // Storage
    always_ff @(posedge clk_sys) begin
        if (push_i) begin
            mem_q[wptr_q[AW-1:0]] <= push_data_i;
        end
    end

    // Pointers carry one wrap bit above the address
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            level_q <= '0;
        end else begin
            if (push_i) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop_i) begin
                rptr_q <= rptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign empty_o = wptr_q == rptr_q;
    assign full_o  = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);
    assign head_o  = mem_q[rptr_q[AW-1:0]];
    assign level_o = level_q;

endmodule

/* src/aout_sample_pkg.sv */
/*
 Stereo sample types shared by the register block, FIFO and PWM engine.
 Left sits in the upper half of a FIFO word and right in the lower half,
 matching the bus layout of a stereo write.
*/
`include "aout_defines.svh"

package aout_sample_pkg;

    // One stereo pair, left channel first
    typedef struct packed {
        logic [`AOUT_SAMPLE_W-1:0] l;
        logic [`AOUT_SAMPLE_W-1:0] r;
    } stereo_sample_t;

    // A FIFO word is written as a raw bus word and read back as halves
    typedef union packed {
        logic [2*`AOUT_SAMPLE_W-1:0] raw;
        stereo_sample_t              lr;
    } fifo_word_u;

endpackage

/* src/ahbl_pkg.sv */
/*
 AHB-Lite encodings seen by the subordinate port.
 Only the transfer type and the one-bit response are described, since
 bursts, protection and locked transfers are not decoded by this block.
*/
package ahbl_pkg;

    // ----------------------------------------
    // Transfer type, HTRANS

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // ----------------------------------------
    // Response, HRESP

    // Both phases of an ERROR drive HRESP_ERROR
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

endpackage

/* src/aout_defines.svh */
/*
 Shared sizes, register offsets and reset values of the audio output block.
 The FIFO depth must stay 2**AOUT_FIFO_ADDR_W, and the level needs one bit more
 than the FIFO address. Only haddr[3:2] selects a register.
*/
`ifndef AOUT_DEFINES_SVH
`define AOUT_DEFINES_SVH

// Sample FIFO geometry
`define AOUT_FIFO_ADDR_W    2
`define AOUT_FIFO_DEPTH     4
`define AOUT_LEVEL_W        3

// Sample and PWM widths, duty is the top PWM_W bits of each channel
`define AOUT_SAMPLE_W       16
`define AOUT_PWM_W          8
`define AOUT_INTERVAL_W     8

// Register map, byte offsets
`define AOUT_ADDR_W         4
`define AOUT_OFS_CSR        4'h0
`define AOUT_OFS_FIFO       4'h4
`define AOUT_OFS_FIFO_MONO  4'h8

// CSR reset values
`define AOUT_INTERVAL_RST   8'd0
`define AOUT_THRESH_RST     3'd0

`endif
